//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen       = 32;   // data path width
    localparam int reg_addr_w = 5;    // 32 architectural registers

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,   // lb lh lw
        op_store  = 7'b0100011,   // sb sh sw
        op_reg    = 7'b0110011,   // R-type
        op_imm    = 7'b0010011,   // addi slli
        op_branch = 7'b1100011,   // beq bne
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // load and store widths
    localparam logic [2:0] f3_byte    = 3'b000;
    localparam logic [2:0] f3_half    = 3'b001;
    localparam logic [2:0] f3_word    = 3'b010;

    // R-type and I-type operations
    localparam logic [2:0] f3_add_sub = 3'b000;   // funct7[5] picks sub
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch conditions
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

endpackage

//--- logic/core_ctrl_pkg.sv
package core_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_xor = 3'b100,
        alu_sll = 3'b101,
        alu_slt = 3'b110
    } alu_op_e;

    // immediate layouts
    typedef enum logic [1:0] {
        imm_i = 2'b00,
        imm_s = 2'b01,
        imm_b = 2'b10,
        imm_j = 2'b11
    } imm_sel_e;

    typedef enum logic [1:0] {
        res_alu = 2'b00,
        res_mem = 2'b01,
        res_pc4 = 2'b10    // link value for jal and jalr
    } result_sel_e;

    typedef enum logic [1:0] {
        pc_next   = 2'b00,   // pc + 4
        pc_target = 2'b01,   // pc + imm
        pc_reg    = 2'b10    // rs1 + imm, bit 0 cleared
    } pc_sel_e;

    // access size of loads and stores
    typedef enum logic [1:0] {
        size_word = 2'b01,
        size_half = 2'b10,
        size_byte = 2'b11
    } mem_size_e;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
(
    input  logic [rv_isa_pkg::xlen-1:0] instr_i,
    input  logic                        zero_i,
    output logic                        reg_we_o,
    output logic                        mem_we_o,
    output core_ctrl_pkg::mem_size_e    mem_size_o,
    output core_ctrl_pkg::result_sel_e  result_sel_o,
    output core_ctrl_pkg::alu_op_e      alu_op_o,
    output logic                        alu_src_o,
    output core_ctrl_pkg::imm_sel_e     imm_sel_o,
    output core_ctrl_pkg::pc_sel_e      pc_sel_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                funct7_b5;

    assign opcode    = rv_isa_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    always_comb
    begin
        // no-op defaults, also what an unknown opcode gets
        reg_we_o     = 1'b0;
        mem_we_o     = 1'b0;
        mem_size_o   = core_ctrl_pkg::size_word;
        result_sel_o = core_ctrl_pkg::res_alu;
        alu_op_o     = core_ctrl_pkg::alu_add;
        alu_src_o    = 1'b0;
        imm_sel_o    = core_ctrl_pkg::imm_i;
        pc_sel_o     = core_ctrl_pkg::pc_next;

        case (opcode)
            rv_isa_pkg::op_load:
            begin
                reg_we_o     = 1'b1;
                alu_src_o    = 1'b1;                       // base + offset
                result_sel_o = core_ctrl_pkg::res_mem;
                case (funct3)
                    rv_isa_pkg::f3_byte: mem_size_o = core_ctrl_pkg::size_byte;
                    rv_isa_pkg::f3_half: mem_size_o = core_ctrl_pkg::size_half;
                    default:             mem_size_o = core_ctrl_pkg::size_word;
                endcase
            end

            rv_isa_pkg::op_store:
            begin
                mem_we_o  = 1'b1;
                alu_src_o = 1'b1;
                imm_sel_o = core_ctrl_pkg::imm_s;
                case (funct3)
                    rv_isa_pkg::f3_byte: mem_size_o = core_ctrl_pkg::size_byte;
                    rv_isa_pkg::f3_half: mem_size_o = core_ctrl_pkg::size_half;
                    default:             mem_size_o = core_ctrl_pkg::size_word;
                endcase
            end

            rv_isa_pkg::op_reg:
            begin
                reg_we_o = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add_sub:
                        alu_op_o = funct7_b5 ? core_ctrl_pkg::alu_sub : core_ctrl_pkg::alu_add;
                    rv_isa_pkg::f3_sll: alu_op_o = core_ctrl_pkg::alu_sll;
                    rv_isa_pkg::f3_slt: alu_op_o = core_ctrl_pkg::alu_slt;
                    rv_isa_pkg::f3_xor: alu_op_o = core_ctrl_pkg::alu_xor;
                    rv_isa_pkg::f3_or:  alu_op_o = core_ctrl_pkg::alu_or;
                    rv_isa_pkg::f3_and: alu_op_o = core_ctrl_pkg::alu_and;
                    default:            alu_op_o = core_ctrl_pkg::alu_add;
                endcase
            end

            rv_isa_pkg::op_imm:
            begin
                reg_we_o  = 1'b1;
                alu_src_o = 1'b1;
                // funct7 bits are immediate bits here, so no sub
                if (funct3 == rv_isa_pkg::f3_sll)
                    alu_op_o = core_ctrl_pkg::alu_sll;
                else
                    alu_op_o = core_ctrl_pkg::alu_add;
            end

            rv_isa_pkg::op_branch:
            begin
                imm_sel_o = core_ctrl_pkg::imm_b;
                alu_op_o  = core_ctrl_pkg::alu_sub;        // compare via zero flag
                if ((funct3 == rv_isa_pkg::f3_beq && zero_i) ||
                    (funct3 == rv_isa_pkg::f3_bne && !zero_i))
                    pc_sel_o = core_ctrl_pkg::pc_target;
            end

            rv_isa_pkg::op_jal:
            begin
                reg_we_o     = 1'b1;
                imm_sel_o    = core_ctrl_pkg::imm_j;
                result_sel_o = core_ctrl_pkg::res_pc4;
                pc_sel_o     = core_ctrl_pkg::pc_target;
            end

            rv_isa_pkg::op_jalr:
            begin
                reg_we_o     = 1'b1;                       // link written too
                alu_src_o    = 1'b1;
                result_sel_o = core_ctrl_pkg::res_pc4;
                pc_sel_o     = core_ctrl_pkg::pc_reg;
            end

            default: ;   // unknown opcode keeps the no-op defaults
        endcase
    end

endmodule

//--- logic/imm_extend.sv
`timescale 1ns/1ps

module imm_extend
(
    input  logic [rv_isa_pkg::xlen-1:0] instr_i,
    input  core_ctrl_pkg::imm_sel_e     imm_sel_i,
    output logic [rv_isa_pkg::xlen-1:0] imm_o
);

    always_comb
    begin
        case (imm_sel_i)
            core_ctrl_pkg::imm_s:
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            core_ctrl_pkg::imm_b:   // halfword offset, lsb always 0
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            core_ctrl_pkg::imm_j:
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            default:                // I format
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu
(
    input  logic [rv_isa_pkg::xlen-1:0] a_i,
    input  logic [rv_isa_pkg::xlen-1:0] b_i,
    input  core_ctrl_pkg::alu_op_e      op_i,
    output logic [rv_isa_pkg::xlen-1:0] result_o,
    output logic                        zero_o
);

    always_comb
    begin
        case (op_i)
            core_ctrl_pkg::alu_add: result_o = a_i + b_i;
            core_ctrl_pkg::alu_sub: result_o = a_i - b_i;
            core_ctrl_pkg::alu_and: result_o = a_i & b_i;
            core_ctrl_pkg::alu_or:  result_o = a_i | b_i;
            core_ctrl_pkg::alu_xor: result_o = a_i ^ b_i;
            core_ctrl_pkg::alu_sll: result_o = a_i << b_i[4:0];   // shamt only
            core_ctrl_pkg::alu_slt:
                result_o = {{(rv_isa_pkg::xlen-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            default:                result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);   // branch compare

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file
(
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_isa_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_isa_pkg::xlen-1:0]       rs2_data_o,
    input  logic                              we_i,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_i,
    input  logic [rv_isa_pkg::xlen-1:0]       rd_data_i
);

    logic [rv_isa_pkg::xlen-1:0] regs [1:31];   // no storage for x0

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        else if (we_i && rd_addr_i != '0)   // x0 writes dropped
            regs[rd_addr_i] <= rd_data_i;
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
(
    input  logic [rv_isa_pkg::xlen-1:0] addr_i,
    input  logic [rv_isa_pkg::xlen-1:0] store_data_i,
    input  core_ctrl_pkg::mem_size_e    size_i,
    input  logic                        we_i,
    output logic [rv_isa_pkg::xlen-1:0] data_addr_o,
    output logic                        data_we_o,
    output logic [3:0]                  data_be_o,
    output logic [rv_isa_pkg::xlen-1:0] data_wdata_o,
    input  logic [rv_isa_pkg::xlen-1:0] data_rdata_i,
    output logic [rv_isa_pkg::xlen-1:0] load_data_o
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign data_addr_o = {addr_i[31:2], 2'b00};   // word aligned bus
    assign data_we_o   = we_i;

    // store lanes and enables
    always_comb
    begin
        case (size_i)
            core_ctrl_pkg::size_byte:
            begin
                data_wdata_o = {4{store_data_i[7:0]}};
                data_be_o    = 4'b0001 << addr_i[1:0];
            end
            core_ctrl_pkg::size_half:
            begin
                data_wdata_o = {2{store_data_i[15:0]}};
                data_be_o    = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                data_wdata_o = store_data_i;
                data_be_o    = 4'b1111;
            end
        endcase
        if (!we_i)
            data_be_o = 4'b0000;   // no enables outside stores
    end

    assign load_byte = data_rdata_i[8*addr_i[1:0] +: 8];
    assign load_half = addr_i[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];

    always_comb
    begin
        case (size_i)
            core_ctrl_pkg::size_byte: load_data_o = {{24{load_byte[7]}}, load_byte};
            core_ctrl_pkg::size_half: load_data_o = {{16{load_half[15]}}, load_half};
            default:                  load_data_o = data_rdata_i;
        endcase
    end

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  core_ctrl_pkg::pc_sel_e      pc_sel_i,
    input  logic [rv_isa_pkg::xlen-1:0] imm_i,
    input  logic [rv_isa_pkg::xlen-1:0] rs1_data_i,
    output logic [rv_isa_pkg::xlen-1:0] pc_o,
    output logic [rv_isa_pkg::xlen-1:0] pc_plus4_o
);

    logic [rv_isa_pkg::xlen-1:0] pc_next;
    logic [rv_isa_pkg::xlen-1:0] reg_target;

    assign pc_plus4_o = pc_o + 32'd4;
    assign reg_target = rs1_data_i + imm_i;

    always_comb
    begin
        case (pc_sel_i)
            core_ctrl_pkg::pc_target: pc_next = pc_o + imm_i;                // branch, jal
            core_ctrl_pkg::pc_reg:    pc_next = {reg_target[31:1], 1'b0};    // jalr
            default:                  pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            pc_o <= core_ctrl_pkg::reset_pc;
        else
            pc_o <= pc_next;
    end

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/1ps

module riscv_core
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    output logic [rv_isa_pkg::xlen-1:0] instr_addr_o,
    input  logic [rv_isa_pkg::xlen-1:0] instr_i,
    output logic [rv_isa_pkg::xlen-1:0] data_addr_o,
    output logic                        data_we_o,
    output logic [3:0]                  data_be_o,
    output logic [rv_isa_pkg::xlen-1:0] data_wdata_o,
    input  logic [rv_isa_pkg::xlen-1:0] data_rdata_i
);

    logic                        reg_we;
    logic                        mem_we;
    core_ctrl_pkg::mem_size_e    mem_size;
    core_ctrl_pkg::result_sel_e  result_sel;
    core_ctrl_pkg::alu_op_e      alu_op;
    logic                        alu_src;
    core_ctrl_pkg::imm_sel_e     imm_sel;
    core_ctrl_pkg::pc_sel_e      pc_sel;
    logic                        zero;

    logic [rv_isa_pkg::xlen-1:0] imm;
    logic [rv_isa_pkg::xlen-1:0] rs1_data;
    logic [rv_isa_pkg::xlen-1:0] rs2_data;
    logic [rv_isa_pkg::xlen-1:0] alu_b;
    logic [rv_isa_pkg::xlen-1:0] alu_result;
    logic [rv_isa_pkg::xlen-1:0] load_data;
    logic [rv_isa_pkg::xlen-1:0] pc_plus4;
    logic [rv_isa_pkg::xlen-1:0] result;

    assign alu_b = alu_src ? imm : rs2_data;   // immediate or rs2

    // writeback source
    always_comb
    begin
        case (result_sel)
            core_ctrl_pkg::res_mem: result = load_data;
            core_ctrl_pkg::res_pc4: result = pc_plus4;
            default:                result = alu_result;
        endcase
    end

    control_unit control_unit_i (
        .instr_i      (instr_i),
        .zero_i       (zero),
        .reg_we_o     (reg_we),
        .mem_we_o     (mem_we),
        .mem_size_o   (mem_size),
        .result_sel_o (result_sel),
        .alu_op_o     (alu_op),
        .alu_src_o    (alu_src),
        .imm_sel_o    (imm_sel),
        .pc_sel_o     (pc_sel)
    );

    imm_extend imm_extend_i (
        .instr_i   (instr_i),
        .imm_sel_i (imm_sel),
        .imm_o     (imm)
    );

    reg_file reg_file_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (reg_we),
        .rd_addr_i  (instr_i[11:7]),
        .rd_data_i  (result)
    );

    alu alu_i (
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    load_store_unit load_store_unit_i (
        .addr_i       (alu_result),
        .store_data_i (rs2_data),
        .size_i       (mem_size),
        .we_i         (mem_we),
        .data_addr_o  (data_addr_o),
        .data_we_o    (data_we_o),
        .data_be_o    (data_be_o),
        .data_wdata_o (data_wdata_o),
        .data_rdata_i (data_rdata_i),
        .load_data_o  (load_data)
    );

    pc_unit pc_unit_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pc_sel_i   (pc_sel),
        .imm_i      (imm),
        .rs1_data_i (rs1_data),
        .pc_o       (instr_addr_o),
        .pc_plus4_o (pc_plus4)
    );

endmodule

//--- testbench/riscv_core_sva.sv
`timescale 1ns/1ps

module riscv_core_sva
(
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic [31:0]              instr_addr_i,
    input logic [31:0]              instr_i,
    input logic                     data_we_i,
    input logic [3:0]               data_be_i,
    input core_ctrl_pkg::mem_size_e mem_size_i,
    input logic [31:0]              rs1_data_i,
    input logic [31:0]              rs2_data_i
);

    be_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !data_we_i |-> data_be_i == 4'b0000)
        else $error("byte enables active without a store");

    // first clock out of reset still fetches from the reset address
    first_fetch: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> instr_addr_i == core_ctrl_pkg::reset_pc)
        else $error("first fetch after reset is not at the reset address");

    fetch_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_addr_i[1:0] == 2'b00)
        else $error("fetch address is not word aligned");

    x0_rs1: assert property (@(posedge clk_i)
        instr_i[19:15] == 5'd0 |-> rs1_data_i == 32'd0)
        else $error("x0 read through rs1 is not zero");

    x0_rs2: assert property (@(posedge clk_i)
        instr_i[24:20] == 5'd0 |-> rs2_data_i == 32'd0)
        else $error("x0 read through rs2 is not zero");

    be_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_we_i |->
        (mem_size_i == core_ctrl_pkg::size_word && data_be_i == 4'b1111) ||
        (mem_size_i == core_ctrl_pkg::size_half &&
         (data_be_i == 4'b0011 || data_be_i == 4'b1100)) ||
        (mem_size_i == core_ctrl_pkg::size_byte && $onehot(data_be_i)))
        else $error("byte enable pattern does not fit the access size");

endmodule

bind riscv_core riscv_core_sva riscv_core_sva_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_addr_i (instr_addr_o),
    .instr_i      (instr_i),
    .data_we_i    (data_we_o),
    .data_be_i    (data_be_o),
    .mem_size_i   (mem_size),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data)
);

//--- testbench/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb;

    localparam int max_cycles = 400;   // about six times the program length

    logic        clk   = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [31:0] data_addr;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] init_mem [64];   // preload image
    logic [31:0] mm [64];         // expected data memory
    logic [31:0] mx [32];         // expected registers
    logic [31:0] exp_fetch [128];
    logic [31:0] exp_addr [64];
    logic [3:0]  exp_be [64];
    logic [31:0] exp_wdata [64];
    logic [31:0] pc = 32'd0;
    logic [31:0] halt_pc = 32'd0;
    logic [31:0] res_addr = 32'h80;   // result words live from here up
    int          n_fetch = 0;
    int          n_store = 0;
    int          fetch_idx = 0;
    int          store_idx = 0;
    int          errors = 0;
    int          cycles = 0;
    int          n_tests = 0;
    int          test_end [8];
    string       test_name [8];

    always #5 clk = ~clk;

    riscv_core riscv_core_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .instr_addr_o (instr_addr),
        .instr_i      (instr),
        .data_addr_o  (data_addr),
        .data_we_o    (data_we),
        .data_be_o    (data_be),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata)
    );

    assign instr      = rst_n ? imem[instr_addr[9:2]] : 32'h0000_0013;   // addi x0,x0,0
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= init_mem[i];
        end
        else if (data_we)
        begin
            for (int b = 0; b < 4; b++)
                if (data_be[b])
                    dmem[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
        end
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            fetch_idx <= fetch_idx + 1;
            if (data_we)
                store_idx <= store_idx + 1;
        end
    end

    function automatic logic [31:0] expected_fetch(input int idx);
        if (idx < n_fetch)
            return exp_fetch[idx];
        else
            return halt_pc;   // spins on the final jal
    endfunction

    function automatic logic [31:0] enc_r(input logic sub, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {1'b0, sub, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input rv_isa_pkg::opcode_e op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2,
                                          input int rs1, input logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], rv_isa_pkg::op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs1,
                                          input int rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11],
                rv_isa_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rv_isa_pkg::op_jal};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pc[9:2]] = word;
        exp_fetch[n_fetch] = pc;
        n_fetch++;
        pc = pc + 4;
    endtask

    task automatic set_reg(input int rd, input logic [31:0] val);
        if (rd != 0)
            mx[rd] = val;
    endtask

    // slots jumped over hold a stray store, so executing one is caught
    task automatic skip_to(input logic [31:0] target);
        while (pc < target)
        begin
            imem[pc[9:2]] = enc_s(12'h0fc, 1, 0, rv_isa_pkg::f3_word);
            pc = pc + 4;
        end
    endtask

    task automatic do_alu(input logic [2:0] f3, input logic sub, input int rd,
                          input int rs1, input int rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = mx[rs1];
        b = mx[rs2];
        case (f3)
            rv_isa_pkg::f3_add_sub: r = sub ? a - b : a + b;
            rv_isa_pkg::f3_slt:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::f3_xor:     r = a ^ b;
            rv_isa_pkg::f3_or:      r = a | b;
            rv_isa_pkg::f3_and:     r = a & b;
            default:                r = a << b[4:0];
        endcase
        set_reg(rd, r);
        emit(enc_r(sub, rs2, rs1, f3, rd));
    endtask

    task automatic do_addi(input int rd, input int rs1, input logic [11:0] imm);
        set_reg(rd, mx[rs1] + {{20{imm[11]}}, imm});
        emit(enc_i(imm, rs1, rv_isa_pkg::f3_add_sub, rd, rv_isa_pkg::op_imm));
    endtask

    task automatic do_slli(input int rd, input int rs1, input logic [4:0] sh);
        set_reg(rd, mx[rs1] << sh);
        emit(enc_i({7'd0, sh}, rs1, rv_isa_pkg::f3_sll, rd, rv_isa_pkg::op_imm));
    endtask

    task automatic do_load(input logic [2:0] f3, input int rd, input logic [11:0] addr);
        logic [31:0] w;
        logic [7:0]  bt;
        logic [15:0] hf;
        w  = mm[addr[7:2]];
        bt = w[{addr[1:0], 3'b000} +: 8];
        hf = addr[1] ? w[31:16] : w[15:0];
        case (f3)
            rv_isa_pkg::f3_byte: set_reg(rd, 32'($signed(bt)));
            rv_isa_pkg::f3_half: set_reg(rd, 32'($signed(hf)));
            default:             set_reg(rd, w);
        endcase
        emit(enc_i(addr, 0, f3, rd, rv_isa_pkg::op_load));
    endtask

    task automatic do_store(input logic [2:0] f3, input int rs2, input logic [11:0] addr);
        logic [31:0] a;
        logic [3:0]  be;
        logic [31:0] wd;
        a = {20'd0, addr};
        case (f3)
            rv_isa_pkg::f3_byte:
            begin
                be = 4'b0001 << a[1:0];
                wd = {4{mx[rs2][7:0]}};   // byte in every lane
            end
            rv_isa_pkg::f3_half:
            begin
                be = a[1] ? 4'b1100 : 4'b0011;
                wd = {2{mx[rs2][15:0]}};
            end
            default:
            begin
                be = 4'b1111;
                wd = mx[rs2];
            end
        endcase
        exp_addr[n_store]  = {a[31:2], 2'b00};
        exp_be[n_store]    = be;
        exp_wdata[n_store] = wd;
        n_store++;
        for (int b = 0; b < 4; b++)
            if (be[b])
                mm[a[7:2]][8*b +: 8] = wd[8*b +: 8];
        emit(enc_s(addr, rs2, 0, f3));
    endtask

    task automatic save(input int rs);
        do_store(rv_isa_pkg::f3_word, rs, res_addr[11:0]);
        res_addr = res_addr + 4;
    endtask

    task automatic do_branch(input logic [2:0] f3, input int rs1, input int rs2);
        logic [31:0] at;
        logic        taken;
        at    = pc;
        taken = (f3 == rv_isa_pkg::f3_beq) ? (mx[rs1] == mx[rs2]) : (mx[rs1] != mx[rs2]);
        emit(enc_b(13'd12, rs1, rs2, f3));
        if (taken)
            skip_to(at + 12);
    endtask

    task automatic do_jal(input int rd);
        logic [31:0] at;
        at = pc;
        set_reg(rd, at + 4);
        emit(enc_j(21'd12, rd));
        skip_to(at + 12);
    endtask

    task automatic do_jalr(input int rd, input int rs1, input logic [11:0] imm);
        logic [31:0] at;
        logic [31:0] target;
        at     = pc;
        target = (mx[rs1] + {{20{imm[11]}}, imm}) & ~32'd1;
        set_reg(rd, at + 4);
        emit(enc_i(imm, rs1, 3'b000, rd, rv_isa_pkg::op_jalr));
        skip_to(target);
    endtask

    task automatic end_test(input string name);
        test_name[n_tests] = name;
        test_end[n_tests]  = n_fetch;
        n_tests++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++)
            imem[i] = {i[24:0], 7'b1111111};   // unknown opcode, varies per address
        for (int i = 0; i < 64; i++)
            init_mem[i] = $urandom;
        init_mem[8] = ($urandom & 32'h7f7f_7f7f) | 32'h8000_8000;   // mixed byte signs
        init_mem[9] = ($urandom & 32'h7fff_7fff) | 32'h8000_0000;   // mixed half signs
        for (int i = 0; i < 64; i++)
            mm[i] = init_mem[i];
        for (int i = 0; i < 32; i++)
            mx[i] = 32'd0;

        do_load(rv_isa_pkg::f3_word, 1, 12'h000);
        do_load(rv_isa_pkg::f3_word, 2, 12'h004);
        do_load(rv_isa_pkg::f3_word, 3, 12'h008);
        do_alu(rv_isa_pkg::f3_add_sub, 1'b0, 4, 1, 2);
        do_alu(rv_isa_pkg::f3_add_sub, 1'b1, 5, 1, 2);
        do_alu(rv_isa_pkg::f3_and, 1'b0, 6, 1, 2);
        do_alu(rv_isa_pkg::f3_or, 1'b0, 7, 1, 2);
        do_alu(rv_isa_pkg::f3_xor, 1'b0, 8, 1, 2);
        do_alu(rv_isa_pkg::f3_slt, 1'b0, 9, 1, 2);
        do_alu(rv_isa_pkg::f3_slt, 1'b0, 10, 2, 1);
        do_addi(11, 1, 12'($urandom));
        do_slli(12, 3, 5'($urandom));
        for (int r = 4; r <= 12; r++)
            save(r);
        end_test("arithmetic");

        for (int k = 0; k < 4; k++)
            do_store(rv_isa_pkg::f3_byte, 1 + k, 12'(32'hf0 + k));
        do_store(rv_isa_pkg::f3_half, 5, 12'h0f4);
        do_store(rv_isa_pkg::f3_half, 6, 12'h0f6);
        end_test("store widths");

        for (int k = 0; k < 4; k++)
        begin
            do_load(rv_isa_pkg::f3_byte, 13, 12'(32'h20 + k));
            save(13);
        end
        do_load(rv_isa_pkg::f3_half, 13, 12'h024);
        save(13);
        do_load(rv_isa_pkg::f3_half, 13, 12'h026);
        save(13);
        do_load(rv_isa_pkg::f3_word, 13, 12'h028);
        save(13);
        end_test("loads");

        do_branch(rv_isa_pkg::f3_beq, 1, 1);
        do_branch(rv_isa_pkg::f3_beq, 1, 2);
        do_branch(rv_isa_pkg::f3_bne, 1, 2);
        do_branch(rv_isa_pkg::f3_bne, 1, 1);
        end_test("branches");

        do_jal(14);
        save(14);
        do_addi(5, 0, 12'(pc + 13));   // jalr sits at pc+4, lands at pc+16
        do_jalr(15, 5, 12'd4);         // odd sum, bit 0 dropped
        save(15);
        end_test("jumps");

        emit({12'h5a5, 5'd2, 3'b000, 5'd1, 7'b1111111});   // rd field points at x1
        save(1);
        end_test("unknown opcode");

        halt_pc = pc;
        emit(enc_j(21'd0, 0));
    endtask

    fetch_check: assert property (@(posedge clk) disable iff (!rst_n)
        instr_addr == expected_fetch(fetch_idx))
    else
    begin
        errors++;
        $display("Error: instr_addr_o expected %h actual %h",
                 expected_fetch($sampled(fetch_idx)), $sampled(instr_addr));
    end

    store_expected: assert property (@(posedge clk) disable iff (!rst_n)
        data_we |-> store_idx < n_store)
    else
    begin
        errors++;
        $display("a store to address %h appeared where the program has none",
                 $sampled(data_addr));
    end

    store_check: assert property (@(posedge clk) disable iff (!rst_n)
        (data_we && store_idx < n_store) |->
        {data_addr, data_be, data_wdata} ==
        {exp_addr[store_idx], exp_be[store_idx], exp_wdata[store_idx]})
    else
    begin
        errors++;
        $display("Error: data_addr_o/data_be_o/data_wdata_o expected %h %h %h actual %h %h %h",
                 exp_addr[$sampled(store_idx)], exp_be[$sampled(store_idx)],
                 exp_wdata[$sampled(store_idx)], $sampled(data_addr),
                 $sampled(data_be), $sampled(data_wdata));
    end

    initial
    begin
        int err_mark;
        int t;
        int n_bad;
        void'($urandom(96302));
        build_program();
        err_mark = 0;
        t        = 0;
        n_bad    = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // run until the core has reached the final jal after the whole program
        while (!(instr_addr == halt_pc && fetch_idx >= n_fetch) && cycles < max_cycles)
        begin
            @(negedge clk);
            cycles++;
            while (t < n_tests && fetch_idx >= test_end[t])
            begin
                $display("test %0d %s: %s", t + 1, test_name[t],
                         (errors == err_mark) ? "ok" : "errors");
                if (errors != err_mark)
                    n_bad++;
                err_mark = errors;
                t++;
            end
        end

        if (cycles >= max_cycles)
        begin
            errors++;
            $display("timeout: the program did not reach its end within %0d cycles",
                     max_cycles);
        end

        assert (store_idx == n_store)
        else
        begin
            errors++;
            $display("%0d stores reached the data port, %0d were expected", store_idx, n_store);
        end
        for (int i = 0; i < 64; i++)
        begin
            assert (dmem[i] == mm[i])   // untouched bytes must keep their preload
            else
            begin
                errors++;
                $display("Error: dmem[%0d] expected %h actual %h", i, mm[i], dmem[i]);
            end
        end

        $display("%0d of %0d tests run, %0d with errors, %0d check errors in total",
                 t, n_tests, n_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- list.f
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/control_unit.sv
logic/imm_extend.sv
logic/alu.sv
logic/reg_file.sv
logic/load_store_unit.sv
logic/pc_unit.sv
logic/riscv_core.sv
testbench/riscv_core_sva.sv
testbench/riscv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module riscv_core_tb -f list.f -o riscv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/riscv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench log decides the result
if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
